//--- logic/rv_config.svh
// width and size macros shared by the execute path
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// register and pc width, also the address width
`define RV_XLEN     32

////////////////////////////////////////
// integer register file
////////////////////////////////////////

`define RV_NREGS    32    // x0 included, x0 reads zero
`define RV_RADDR_W  5     // log2 of RV_NREGS

`endif

//--- logic/rv_pkg.sv
// word, register index and instruction types, opcode, alu, branch and operand enums
`include "rv_config.svh"

package rv_pkg;

  ////////////////////////////////////////
  // basic types
  ////////////////////////////////////////

  typedef logic [`RV_XLEN-1:0]    word_t;      // register or pc value
  typedef logic [`RV_RADDR_W-1:0] reg_addr_t;  // register index
  typedef logic [31:0]            instr_t;     // one rv32i instruction word

  // major opcodes kept in this path, all else is a bubble
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  ////////////////////////////////////////
  // execute controls
  ////////////////////////////////////////

  // encoded as {funct7[5], funct3} so OP decodes straight through
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE = 4'd0,  // not a control transfer
    BR_BEQ  = 4'd1,
    BR_BNE  = 4'd2,
    BR_BLT  = 4'd3,
    BR_BGE  = 4'd4,
    BR_BLTU = 4'd5,
    BR_BGEU = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } br_op_e;

  // alu operand a source
  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2   // lui
  } a_sel_e;

endpackage

//--- logic/rv_ex_if.sv
// execute-stage bundle with decoder, alu, branch unit and write-back views
`timescale 1ns/1ps

interface rv_ex_if;
  import rv_pkg::*;

  logic    valid;     // stage holds a live instruction
  word_t   pc;
  word_t   rs1_val;   // already bypassed
  word_t   rs2_val;
  word_t   imm;       // i/u/b/j, picked by decode
  a_sel_e  a_sel;
  logic    b_is_imm;  // operand b from imm, else rs2
  alu_op_e alu_op;
  br_op_e  br_op;
  reg_addr_t dst;
  logic    writes;    // instruction targets rd

  // decoder owns the execute register
  modport dec (output valid, pc, rs1_val, rs2_val, imm, a_sel, b_is_imm,
               alu_op, br_op, dst, writes);

  modport alu (input pc, rs1_val, rs2_val, imm, a_sel, b_is_imm, alu_op);

  modport bru (input pc, rs1_val, rs2_val, imm, br_op);

  // write-back only needs the destination side
  modport wbk (input valid, dst, writes);

endinterface

//--- logic/rv_decoder.sv
// rv32i decode, immediate build, operand bypass and decode/execute register
`timescale 1ns/1ps

module rv_decoder
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              instr_valid_i,
  input  rv_pkg::instr_t    instr_i,
  input  rv_pkg::word_t     pc_i,
  output rv_pkg::reg_addr_t rs1_addr_o,     // to register file
  output rv_pkg::reg_addr_t rs2_addr_o,
  input  rv_pkg::word_t     rs1_data_i,
  input  rv_pkg::word_t     rs2_data_i,
  input  logic              exf_valid_i,    // execute-stage bypass
  input  rv_pkg::reg_addr_t exf_dst_i,
  input  rv_pkg::word_t     exf_data_i,
  input  logic              wbf_we_i,       // write-back bypass
  input  rv_pkg::reg_addr_t wbf_dst_i,
  input  rv_pkg::word_t     wbf_data_i,
  rv_ex_if.dec              ex
);
  import rv_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  word_t      imm_i, imm_u, imm_b, imm_j;

  logic       legal;       // known opcode and funct
  logic       d_writes;
  logic       d_b_is_imm;
  a_sel_e     d_a_sel;
  alu_op_e    d_alu_op;
  br_op_e     d_br_op;
  word_t      d_imm;
  word_t      rs1_fwd, rs2_fwd;

  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rd         = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'h000};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////////////////////////
  // opcode / funct decode
  ////////////////////////////////////////

  always_comb
  begin
    legal      = 1'b1;
    d_writes   = 1'b1;
    d_b_is_imm = 1'b1;
    d_a_sel    = A_RS1;
    d_alu_op   = ALU_ADD;
    d_br_op    = BR_NONE;
    d_imm      = imm_i;

    case (opcode_e'(instr_i[6:0]))
      OPC_OP:
      begin
        d_b_is_imm = 1'b0;
        d_alu_op   = alu_op_e'({funct7[5], funct3});
        // only sub and sra use funct7 = 0x20
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
          legal = 1'b0;
      end
      OPC_OP_IMM:
      begin
        d_alu_op = alu_op_e'({1'b0, funct3});  // no subi
        if (funct3 == 3'b001 && funct7 != 7'b0000000)
          legal = 1'b0;
        if (funct3 == 3'b101)
        begin
          if (funct7 == 7'b0100000)
            d_alu_op = ALU_SRA;
          else if (funct7 != 7'b0000000)
            legal = 1'b0;
        end
      end
      OPC_LUI:
      begin
        d_a_sel = A_ZERO;   // 0 + imm
        d_imm   = imm_u;
      end
      OPC_AUIPC:
      begin
        d_a_sel = A_PC;
        d_imm   = imm_u;
      end
      OPC_JAL:
      begin
        d_br_op = BR_JAL;
        d_imm   = imm_j;
      end
      OPC_JALR:
      begin
        d_br_op = BR_JALR;
        legal   = (funct3 == 3'b000);
      end
      OPC_BRANCH:
      begin
        d_writes   = 1'b0;
        d_b_is_imm = 1'b0;
        d_imm      = imm_b;
        case (funct3)
          3'b000:  d_br_op = BR_BEQ;
          3'b001:  d_br_op = BR_BNE;
          3'b100:  d_br_op = BR_BLT;
          3'b101:  d_br_op = BR_BGE;
          3'b110:  d_br_op = BR_BLTU;
          3'b111:  d_br_op = BR_BGEU;
          default: legal   = 1'b0;
        endcase
      end
      default: legal = 1'b0;   // bubble
    endcase
  end

  ////////////////////////////////////////
  // bypass, newest result wins
  ////////////////////////////////////////

  function automatic word_t fwd(reg_addr_t a, word_t rf_val);
    if (a == '0)
      return '0;                          // x0 never bypassed
    else if (exf_valid_i && exf_dst_i == a)
      return exf_data_i;                  // one ahead, still in execute
    else if (wbf_we_i && wbf_dst_i == a)
      return wbf_data_i;                  // two ahead, not yet in rf
    else
      return rf_val;
  endfunction

  always_comb
  begin
    rs1_fwd = fwd(rs1_addr_o, rs1_data_i);
    rs2_fwd = fwd(rs2_addr_o, rs2_data_i);
  end

  // execute register, only valid is control
  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
      ex.valid <= 1'b0;
    else
      ex.valid <= instr_valid_i & legal;
  end

  always_ff @(posedge clk)
  begin
    ex.pc       <= pc_i;
    ex.rs1_val  <= rs1_fwd;
    ex.rs2_val  <= rs2_fwd;
    ex.imm      <= d_imm;
    ex.a_sel    <= d_a_sel;
    ex.b_is_imm <= d_b_is_imm;
    ex.alu_op   <= d_alu_op;
    ex.br_op    <= d_br_op;
    ex.dst      <= rd;
    ex.writes   <= d_writes;
  end

endmodule

//--- logic/rv_regfile.sv
// integer register file, two read ports, one write port, x0 tied to zero
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile
(
  input  logic              clk,
  input  logic              rstn,
  input  rv_pkg::reg_addr_t rs1_addr_i,
  input  rv_pkg::reg_addr_t rs2_addr_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o,
  input  logic              we_i,
  input  rv_pkg::reg_addr_t dst_i,
  input  rv_pkg::word_t     data_i
);
  import rv_pkg::*;

  // x1..x31 only, x0 has no storage
  word_t regs [1:`RV_NREGS-1];

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      for (int i = 1; i < `RV_NREGS; i++)
        regs[i] <= '0;
    end
    else if (we_i && dst_i != '0)   // x0 writes dropped
    begin
      regs[dst_i] <= data_i;
    end
  end

  // async read, no internal write-through
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- logic/rv_alu.sv
// operand select and integer alu, add/sub, logic, shifts and compares
`timescale 1ns/1ps

module rv_alu
(
  rv_ex_if.alu          ex,
  output rv_pkg::word_t result_o
);
  import rv_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  ////////////////////////////////////////
  // operands
  ////////////////////////////////////////

  always_comb
  begin
    case (ex.a_sel)
      A_PC:    op_a = ex.pc;    // auipc
      A_ZERO:  op_a = '0;       // lui
      default: op_a = ex.rs1_val;
    endcase
  end

  assign op_b  = ex.b_is_imm ? ex.imm : ex.rs2_val;
  assign shamt = op_b[4:0];     // upper bits ignored

  always_comb
  begin
    case (ex.alu_op)
      ALU_ADD:  result_o = op_a + op_b;
      ALU_SUB:  result_o = op_a - op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SLT:  result_o = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: result_o = word_t'(op_a < op_b);
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SRL:  result_o = op_a >> shamt;
      ALU_SRA:  result_o = word_t'($signed(op_a) >>> shamt);  // sign fill
      ALU_OR:   result_o = op_a | op_b;
      ALU_AND:  result_o = op_a & op_b;
      default:  result_o = op_a + op_b;
    endcase
  end

endmodule

//--- logic/rv_branch_unit.sv
// branch compare, jump and branch target, link address
`timescale 1ns/1ps

module rv_branch_unit
(
  rv_ex_if.bru          ex,
  output logic          taken_o,
  output rv_pkg::word_t target_o,
  output rv_pkg::word_t link_o
);
  import rv_pkg::*;

  logic  eq;
  logic  lt_s;     // signed less than
  logic  lt_u;
  word_t base;
  word_t sum;

  ////////////////////////////////////////
  // condition
  ////////////////////////////////////////

  assign eq   = (ex.rs1_val == ex.rs2_val);
  assign lt_s = ($signed(ex.rs1_val) < $signed(ex.rs2_val));
  assign lt_u = (ex.rs1_val < ex.rs2_val);

  always_comb
  begin
    case (ex.br_op)
      BR_BEQ:  taken_o = eq;
      BR_BNE:  taken_o = ~eq;
      BR_BLT:  taken_o = lt_s;
      BR_BGE:  taken_o = ~lt_s;
      BR_BLTU: taken_o = lt_u;
      BR_BGEU: taken_o = ~lt_u;
      BR_JAL,
      BR_JALR: taken_o = 1'b1;   // jumps always go
      default: taken_o = 1'b0;   // not a control transfer
    endcase
  end

  ////////////////////////////////////////
  // target and link
  ////////////////////////////////////////

  // jalr is register relative, everything else pc relative
  assign base = (ex.br_op == BR_JALR) ? ex.rs1_val : ex.pc;
  assign sum  = base + ex.imm;

  always_comb
  begin
    if (ex.br_op == BR_JALR)
      target_o = sum & ~word_t'(1);   // lsb cleared per spec
    else
      target_o = sum;
  end

  // return address for jal/jalr
  assign link_o = ex.pc + word_t'(4);

endmodule

//--- logic/rv_writeback.sv
// result merge, execute bypass, write-back register and outcome outputs
`timescale 1ns/1ps

module rv_writeback
(
  input  logic              clk,
  input  logic              rstn,
  rv_ex_if.wbk              ex,
  input  rv_pkg::word_t     alu_result_i,
  input  logic              br_taken_i,
  input  rv_pkg::word_t     br_target_i,
  input  rv_pkg::word_t     link_i,
  input  logic              br_is_jump_i,     // jal / jalr
  input  logic              br_is_branch_i,   // conditional
  output logic              exf_valid_o,      // bypass to decode
  output rv_pkg::reg_addr_t exf_dst_o,
  output rv_pkg::word_t     exf_data_o,
  output logic              wb_valid_o,
  output logic              wb_we_o,
  output rv_pkg::reg_addr_t wb_dst_o,
  output rv_pkg::word_t     wb_data_o,
  output logic              br_valid_o,
  output logic              br_taken_o,
  output rv_pkg::word_t     br_target_o
);
  import rv_pkg::*;

  word_t result;
  logic  we;
  logic  is_xfer;   // any control transfer

  ////////////////////////////////////////
  // execute-cycle merge
  ////////////////////////////////////////

  assign result  = br_is_jump_i ? link_i : alu_result_i;
  assign is_xfer = br_is_jump_i | br_is_branch_i;

  // branches and rd = x0 never write
  assign we = ex.valid & ex.writes & ~br_is_branch_i & (ex.dst != '0);

  assign exf_valid_o = we;
  assign exf_dst_o   = ex.dst;
  assign exf_data_o  = result;

  ////////////////////////////////////////
  // write-back register
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      wb_valid_o  <= 1'b0;
      wb_we_o     <= 1'b0;
      wb_dst_o    <= '0;
      wb_data_o   <= '0;
      br_valid_o  <= 1'b0;
      br_taken_o  <= 1'b0;
      br_target_o <= '0;
    end
    else
    begin
      wb_valid_o <= ex.valid;
      wb_we_o    <= we;
      br_valid_o <= ex.valid & is_xfer;
      br_taken_o <= ex.valid & is_xfer & br_taken_i;
      if (ex.valid)   // payload holds over bubbles
      begin
        wb_dst_o    <= ex.dst;
        wb_data_o   <= result;
        br_target_o <= br_target_i;
      end
    end
  end

endmodule

//--- logic/rv_exec_core.sv
// execute path top, decode, register file, alu, branch unit and write-back
`timescale 1ns/1ps

module rv_exec_core
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              instr_valid_i,
  input  rv_pkg::instr_t    instr_i,
  input  rv_pkg::word_t     pc_i,
  output logic              wb_valid_o,
  output logic              wb_we_o,
  output rv_pkg::reg_addr_t wb_dst_o,
  output rv_pkg::word_t     wb_data_o,
  output logic              br_valid_o,
  output logic              br_taken_o,
  output rv_pkg::word_t     br_target_o
);
  import rv_pkg::*;

  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  logic      exf_valid;
  reg_addr_t exf_dst;
  word_t     exf_data;
  word_t     alu_result;
  logic      br_taken;
  word_t     br_target, link;
  logic      br_is_jump, br_is_branch;

  rv_ex_if ex ();   // decode -> execute register

  // control transfer class of the execute-stage instruction
  assign br_is_jump   = (ex.br_op == BR_JAL) || (ex.br_op == BR_JALR);
  assign br_is_branch = (ex.br_op != BR_NONE) && !br_is_jump;

  ////////////////////////////////////////
  // decode and register read
  ////////////////////////////////////////

  rv_decoder u_decoder (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .pc_i          ( pc_i          ),
    .rs1_addr_o    ( rs1_addr      ),
    .rs2_addr_o    ( rs2_addr      ),
    .rs1_data_i    ( rs1_data      ),
    .rs2_data_i    ( rs2_data      ),
    .exf_valid_i   ( exf_valid     ),
    .exf_dst_i     ( exf_dst       ),
    .exf_data_i    ( exf_data      ),
    .wbf_we_i      ( wb_we_o       ),   // write-back register as bypass
    .wbf_dst_i     ( wb_dst_o      ),
    .wbf_data_i    ( wb_data_o     ),
    .ex            ( ex            )
  );

  rv_regfile u_regfile (
    .clk        ( clk       ),
    .rstn       ( rstn      ),
    .rs1_addr_i ( rs1_addr  ),
    .rs2_addr_i ( rs2_addr  ),
    .rs1_data_o ( rs1_data  ),
    .rs2_data_o ( rs2_data  ),
    .we_i       ( wb_we_o   ),   // written at end of wb cycle
    .dst_i      ( wb_dst_o  ),
    .data_i     ( wb_data_o )
  );

  ////////////////////////////////////////
  // execute and write-back
  ////////////////////////////////////////

  rv_alu u_alu (
    .ex       ( ex         ),
    .result_o ( alu_result )
  );

  rv_branch_unit u_branch_unit (
    .ex       ( ex        ),
    .taken_o  ( br_taken  ),
    .target_o ( br_target ),
    .link_o   ( link      )
  );

  rv_writeback u_writeback (
    .clk            ( clk          ),
    .rstn           ( rstn         ),
    .ex             ( ex           ),
    .alu_result_i   ( alu_result   ),
    .br_taken_i     ( br_taken     ),
    .br_target_i    ( br_target    ),
    .link_i         ( link         ),
    .br_is_jump_i   ( br_is_jump   ),
    .br_is_branch_i ( br_is_branch ),
    .exf_valid_o    ( exf_valid    ),
    .exf_dst_o      ( exf_dst      ),
    .exf_data_o     ( exf_data     ),
    .wb_valid_o     ( wb_valid_o   ),
    .wb_we_o        ( wb_we_o      ),
    .wb_dst_o       ( wb_dst_o     ),
    .wb_data_o      ( wb_data_o    ),
    .br_valid_o     ( br_valid_o   ),
    .br_taken_o     ( br_taken_o   ),
    .br_target_o    ( br_target_o  )
  );

endmodule

//--- test/rv_exec_core_chk.sv
// output protocol assertions for the execute path, bound into the top level
`timescale 1ns/1ps

module rv_exec_core_chk
(
  input logic              clk,
  input logic              rstn,
  input logic              wb_valid_i,
  input logic              wb_we_i,
  input rv_pkg::reg_addr_t wb_dst_i,
  input logic              br_valid_i,
  input logic              br_taken_i
);

  int unsigned err_cnt = 0;   // failed assertions so far

  // a write belongs to a live instruction with a real rd
  we_has_valid: assert property (@(posedge clk) disable iff (!rstn)
      wb_we_i |-> (wb_valid_i && wb_dst_i != '0))
    else
    begin
      $error("wb_we_o high without wb_valid_o or with destination x0");
      err_cnt++;
    end

  taken_has_valid: assert property (@(posedge clk) disable iff (!rstn)
      br_taken_i |-> br_valid_i)
    else
    begin
      $error("br_taken_o high without br_valid_o");
      err_cnt++;
    end

  // async reset, flags must already be clear
  quiet_in_reset: assert property (@(posedge clk)
      !rstn |-> !(wb_valid_i || wb_we_i || br_valid_i || br_taken_i))
    else
    begin
      $error("output flag high while rstn is low");
      err_cnt++;
    end

endmodule

bind rv_exec_core rv_exec_core_chk u_chk (
  .clk        ( clk        ),
  .rstn       ( rstn       ),
  .wb_valid_i ( wb_valid_o ),
  .wb_we_i    ( wb_we_o    ),
  .wb_dst_i   ( wb_dst_o   ),
  .br_valid_i ( br_valid_o ),
  .br_taken_i ( br_taken_o )
);

//--- test/tb_rv_exec_core.sv
// testbench for the execute path, random instruction stream, reference model and checks
`timescale 1ns/1ps

module tb_rv_exec_core;
  import rv_pkg::*;

  localparam int NREGS   = 32;
  localparam int N_INSTR = 400;   // random instructions after the idle warm-up
  localparam int LAT     = 2;     // falling edges from drive to visible result

  typedef struct packed {
    logic [31:0] due;       // check edge number
    logic        valid;
    logic        we;
    reg_addr_t   dst;
    word_t       data;
    logic        br_valid;
    logic        br_taken;
    word_t       br_target;
  } exp_t;

  logic      clk;
  logic      rstn;
  logic      instr_valid_i;
  instr_t    instr_i;
  word_t     pc_i;
  logic      wb_valid_o, wb_we_o, br_valid_o, br_taken_o;
  reg_addr_t wb_dst_o;
  word_t     wb_data_o, br_target_o;

  integer    seed;
  int        cyc;             // falling edges since reset release
  word_t     pc;              // model pc
  word_t     xreg [NREGS];    // model register file
  exp_t      exp_q [$];

  rv_exec_core dut (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .pc_i          ( pc_i          ),
    .wb_valid_o    ( wb_valid_o    ),
    .wb_we_o       ( wb_we_o       ),
    .wb_dst_o      ( wb_dst_o      ),
    .wb_data_o     ( wb_data_o     ),
    .br_valid_o    ( br_valid_o    ),
    .br_taken_o    ( br_taken_o    ),
    .br_target_o   ( br_target_o   )
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  ////////////////////////////////////////
  // failure and compare tasks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_wb(input logic valid, input logic we, input reg_addr_t dst,
                          input word_t data);
    string msg;
    msg = "";
    if (wb_valid_o !== valid)
      msg = $sformatf("error at %0t: wb_valid_o %b, expected %b", $time, wb_valid_o, valid);
    else if (wb_we_o !== we)
      msg = $sformatf("error at %0t: wb_we_o %b, expected %b", $time, wb_we_o, we);
    else if (we && wb_dst_o !== dst)
      msg = $sformatf("error at %0t: wb_dst_o x%0d, expected x%0d", $time, wb_dst_o, dst);
    else if (we && wb_data_o !== data)
      msg = $sformatf("error at %0t: wb_data_o %h, expected %h", $time, wb_data_o, data);
    if (msg != "")
      abort_run(msg);
  endtask

  task automatic check_br(input logic valid, input logic taken, input word_t target);
    string msg;
    msg = "";
    if (br_valid_o !== valid)
      msg = $sformatf("error at %0t: br_valid_o %b, expected %b", $time, br_valid_o, valid);
    else if (br_taken_o !== taken)
      msg = $sformatf("error at %0t: br_taken_o %b, expected %b", $time, br_taken_o, taken);
    else if (valid && br_target_o !== target)
      msg = $sformatf("error at %0t: br_target_o %h, expected %h", $time, br_target_o, target);
    if (msg != "")
      abort_run(msg);
  endtask

  task automatic check_chk();
    if (dut.u_chk.err_cnt != 0)
      abort_run("an assertion on the DUT outputs failed in the bound checker");
  endtask

  ////////////////////////////////////////
  // reference model, rv32i rules
  ////////////////////////////////////////

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0: alu_ref = alt ? a - b : a + b;
      3'd1: alu_ref = a << b[4:0];
      3'd2: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: alu_ref = (a < b) ? 32'd1 : 32'd0;
      3'd4: alu_ref = a ^ b;
      3'd5:
      begin
        if (alt)
          alu_ref = $signed(a) >>> b[4:0];   // arithmetic
        else
          alu_ref = a >> b[4:0];
      end
      3'd6: alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: br_ref = (a == b);
      3'd1: br_ref = (a != b);
      3'd4: br_ref = ($signed(a) < $signed(b));
      3'd5: br_ref = ($signed(a) >= $signed(b));
      3'd6: br_ref = (a < b);
      default: br_ref = (a >= b);
    endcase
  endfunction

  task automatic run_model(input logic valid, input instr_t ins, output exp_t e);
    reg_addr_t  rd;
    logic [2:0] f3;
    word_t      a, b, imm_i, imm_u, imm_b, imm_j;
    e     = '0;
    rd    = ins[11:7];
    f3    = ins[14:12];
    a     = xreg[ins[19:15]];
    b     = xreg[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'h000};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    e.dst = rd;
    if (valid)
    begin
      e.valid = 1'b1;
      case (ins[6:0])
        7'b0110011: e.data = alu_ref(f3, ins[30], a, b);                   // op
        7'b0010011: e.data = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);  // op-imm
        7'b0110111: e.data = imm_u;                                       // lui
        7'b0010111: e.data = pc + imm_u;                                  // auipc
        7'b1101111:
        begin
          e.data      = pc + 32'd4;
          e.br_valid  = 1'b1;
          e.br_taken  = 1'b1;
          e.br_target = pc + imm_j;
        end
        7'b1100111:
        begin
          e.data      = pc + 32'd4;
          e.br_valid  = 1'b1;
          e.br_taken  = 1'b1;
          e.br_target = (a + imm_i) & ~32'd1;
        end
        7'b1100011:
        begin
          e.br_valid  = 1'b1;
          e.br_taken  = br_ref(f3, a, b);
          e.br_target = pc + imm_b;
        end
        default: e.valid = 1'b0;   // unknown opcode, bubble
      endcase
    end
    e.we = e.valid && ins[6:0] != 7'b1100011 && rd != 5'd0;
    if (e.we)
      xreg[rd] = e.data;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // random kept instruction over x0..x7, some bubbles and idles
  task automatic gen_instr(output logic valid, output instr_t ins);
    logic [31:0] s;
    logic [2:0]  f3;
    ins        = $random(seed);
    s          = $random(seed);
    valid      = 1'b1;
    ins[11:7]  = {2'b00, s[2:0]};
    ins[19:15] = {2'b00, s[5:3]};
    f3         = ins[14:12];
    case (s[31:28])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
      begin
        ins[6:0]   = 7'b0110011;
        ins[24:20] = {2'b00, s[8:6]};
        ins[31:25] = (s[9] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      end
      4'd5, 4'd6, 4'd7:
      begin
        ins[6:0] = 7'b0010011;
        if (f3 == 3'd1)
          ins[31:25] = 7'h00;
        else if (f3 == 3'd5)
          ins[31:25] = s[9] ? 7'h20 : 7'h00;
        else if (s[10])
          ins[31:24] = 8'h00;   // small value, more equal operands
      end
      4'd8:  ins[6:0] = 7'b0110111;
      4'd9:  ins[6:0] = 7'b0010111;
      4'd10, 4'd11:
      begin
        ins[6:0]   = 7'b1100011;
        ins[24:20] = {2'b00, s[8:6]};
        f3         = s[12:10];
        if (f3[2:1] == 2'b01)
          f3[2] = 1'b1;         // 2 and 3 are reserved
        ins[14:12] = f3;
      end
      4'd12: ins[6:0] = 7'b1101111;
      4'd13:
      begin
        ins[6:0]   = 7'b1100111;
        ins[14:12] = 3'd0;
      end
      4'd14: ins[6:0] = s[9] ? 7'b0000011 : 7'b0100011;   // load/store, dropped
      default: valid = 1'b0;
    endcase
  endtask

  task automatic drive(input logic valid, input instr_t ins);
    exp_t e;
    run_model(valid, ins, e);
    e.due         = cyc + LAT;
    instr_valid_i = valid;
    instr_i       = ins;
    pc_i          = pc;
    exp_q.push_back(e);
    if (valid)
      pc = pc + 32'd4;
  endtask

  // one falling edge, check anything that is due
  task automatic tick();
    exp_t e;
    @(negedge clk);
    cyc++;
    check_chk();
    if (exp_q.size() != 0 && exp_q[0].due == cyc)
    begin
      e = exp_q.pop_front();
      check_wb(e.valid, e.we, e.dst, e.data);
      check_br(e.br_valid, e.br_taken, e.br_target);
    end
  endtask

  initial
  begin
    logic   v;
    instr_t ins;
    int     guard;
    seed          = 26736;
    cyc           = 0;
    pc            = 32'h0000_1000;
    rstn          = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    for (int i = 0; i < NREGS; i++)
      xreg[i] = '0;
    #1 rstn = 1'b0;   // reset falls just after time 0
    repeat (10) @(posedge clk);
    tick();
    rstn = 1'b1;
    for (int i = 0; i < 6; i++)   // idle after reset, nothing may appear
    begin
      tick();
      drive(1'b0, '0);
    end
    for (int i = 0; i < N_INSTR; i++)
    begin
      tick();
      gen_instr(v, ins);
      drive(v, ins);
    end
    guard = 0;
    while (exp_q.size() != 0)
    begin
      tick();
      instr_valid_i = 1'b0;
      guard++;
      if (guard > 2 * LAT)
        abort_run("timeout, expected results still pending after the stream ended");
    end
    if (dut.u_chk.err_cnt == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
      abort_run("an assertion on the DUT outputs failed in the last cycles");
  end

endmodule

//--- rv_exec_core.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_ex_if.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_branch_unit.sv
logic/rv_writeback.sv
logic/rv_exec_core.sv
test/rv_exec_core_chk.sv
test/tb_rv_exec_core.sv
